// ==== hybrid_tank_pkg.sv ====
`default_nettype none

package hybrid_tank_pkg;

   // ==========================================================================
   // widths
   // ==========================================================================
   localparam int SAMPLE_W = 14;   // tank adc word, two's complement
   localparam int GAIN_W   = 8;    // surface weights and slope
   localparam int THRESH_W = 24;   // hysteresis half band
   localparam int GATE_W   = 4;    // q1 q2 q3 q4 on bits 0..3

   // control mode, follows the front panel switch code
   typedef enum logic [1:0] {
      MODE_PHI   = 2'd0,   // vc and ic surface
      MODE_THETA = 2'd1,   // vc only
      MODE_HOLD  = 2'd2,   // reserved code, treated as off
      MODE_OFF   = 2'd3
   } ctrl_mode_t;

   // switching variable, 2 bit signed so neg reads as -1
   typedef enum logic [1:0] {
      SIGMA_ZERO = 2'b00,   // low side on
      SIGMA_POS  = 2'b01,   // q1 and q4
      SIGMA_NEG  = 2'b11    // q2 and q3
   } sigma_t;

   typedef enum logic [1:0] {
      PHASE_IDLE      = 2'd0,
      PHASE_BOOT      = 2'd1,   // bootstrap caps charging
      PHASE_PRECHARGE = 2'd2,   // tank pumped with sigma +1
      PHASE_RUN       = 2'd3
   } bridge_phase_t;

   // gate patterns, leg a is q1/q3 and leg b is q2/q4
   localparam logic [GATE_W-1:0] GATE_OFF = 4'b0000;
   localparam logic [GATE_W-1:0] GATE_POS = 4'b1001;   // q1 q4
   localparam logic [GATE_W-1:0] GATE_NEG = 4'b0110;   // q2 q3
   localparam logic [GATE_W-1:0] GATE_LOW = 4'b1100;   // q3 q4, also boot pattern

   localparam int unsigned DAC_OFFSET = 8191;   // mid scale for monitor dac

   // default tuning
   localparam int MU_VC            = 86;
   localparam int MU_IC            = 90;
   localparam int BOOT_CYCLES      = 10;
   localparam int PRECHARGE_CYCLES = 16;
   localparam int DEAD_CYCLES      = 8;

endpackage

`default_nettype wire

// ==== adc_sample_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_sample_capture #(
   parameter int SAMPLE_W = hybrid_tank_pkg::SAMPLE_W
) (
   input  logic                       ADA_DCO,
   input  logic                       i_reset,
   input  logic signed [SAMPLE_W-1:0] i_vc_raw,   // capacitor voltage, raw
   input  logic signed [SAMPLE_W-1:0] i_ic_raw,   // inductor current, raw
   input  logic                       i_vc_or,
   input  logic                       i_ic_or,
   output logic signed [SAMPLE_W-1:0] o_vc,
   output logic signed [SAMPLE_W-1:0] o_ic,
   output logic        [SAMPLE_W-1:0] o_dac_vc,   // offset binary copy
   output logic                       o_adc_or    // sticky out of range
);

   import hybrid_tank_pkg::*;

   localparam logic [SAMPLE_W-1:0] DAC_MID = SAMPLE_W'(DAC_OFFSET);

   logic signed [SAMPLE_W-1:0] vc_neg;
   logic signed [SAMPLE_W-1:0] ic_neg;

   // sensors are wired with reversed polarity
   assign vc_neg = -i_vc_raw;   // wraps at full scale, -8192 stays -8192
   assign ic_neg = -i_ic_raw;

   // ==========================================================================
   // one register stage on the adc data clock
   // ==========================================================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_vc     <= '0;
         o_ic     <= '0;
         o_dac_vc <= '0;
         o_adc_or <= 1'b0;
      end else begin
         o_vc     <= vc_neg;
         o_ic     <= ic_neg;
         o_dac_vc <= $unsigned(vc_neg) + DAC_MID;   // mod 2^14

         // latch any overrange until reset
         if (i_vc_or || i_ic_or) begin
            o_adc_or <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== switching_surface_law.sv ====
`timescale 1ns/1ps
`default_nettype none

module switching_surface_law #(
   parameter int SAMPLE_W = hybrid_tank_pkg::SAMPLE_W,
   parameter int GAIN_W   = hybrid_tank_pkg::GAIN_W,
   parameter int MU_VC    = hybrid_tank_pkg::MU_VC,
   parameter int MU_IC    = hybrid_tank_pkg::MU_IC
) (
   input  logic                                 ADA_DCO,
   input  logic                                 i_reset,
   input  logic signed [SAMPLE_W-1:0]           i_vc,
   input  logic signed [SAMPLE_W-1:0]           i_ic,
   input  hybrid_tank_pkg::ctrl_mode_t          i_mode,
   input  logic signed [GAIN_W-1:0]             i_slope,       // surface tilt on ic
   input  logic [hybrid_tank_pkg::THRESH_W-1:0] i_threshold,   // half band, unsigned
   output hybrid_tank_pkg::sigma_t              o_sigma
);

   import hybrid_tank_pkg::*;

   // sample x mu x slope, plus one bit of headroom for the sum
   localparam int TERM_W = SAMPLE_W + 2 * GAIN_W;
   localparam int SURF_W = TERM_W + 1;

   // weights as signed constants so the products stay signed
   localparam logic signed [GAIN_W:0] MU_VC_K = (GAIN_W + 1)'(MU_VC);
   localparam logic signed [GAIN_W:0] MU_IC_K = (GAIN_W + 1)'(MU_IC);

   logic signed [TERM_W-1:0] vc_term_q;
   logic signed [TERM_W-1:0] ic_term_q;
   ctrl_mode_t               mode_q;      // mode aligned with the terms

   logic signed [SURF_W-1:0] surf;
   logic signed [SURF_W-1:0] band_hi;
   logic signed [SURF_W-1:0] band_lo;

   // ==========================================================================
   // stage a, weighted products
   // ==========================================================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         vc_term_q <= '0;
         ic_term_q <= '0;
         mode_q    <= MODE_OFF;
      end else begin
         vc_term_q <= (i_vc * MU_VC_K) <<< 4;   // x16 matches slope scale
         if (i_mode == MODE_THETA) begin
            ic_term_q <= '0;   // theta looks at vc only
         end else begin
            ic_term_q <= i_ic * MU_IC_K * i_slope;
         end
         mode_q    <= i_mode;
      end
   end

   // surface and band edges
   assign surf    = vc_term_q + ic_term_q;   // both sign extended
   assign band_hi = $signed({{(SURF_W - THRESH_W){1'b0}}, i_threshold});
   assign band_lo = -band_hi;

   // ==========================================================================
   // stage b, hysteresis on sigma
   // ==========================================================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_sigma <= SIGMA_ZERO;
      end else if (mode_q == MODE_OFF || mode_q == MODE_HOLD) begin
         o_sigma <= SIGMA_ZERO;   // converter parked on low side
      end else begin
         case (o_sigma)
            SIGMA_ZERO: begin
               o_sigma <= SIGMA_POS;   // kick the tank
            end
            SIGMA_POS: begin
               if (surf > band_hi) begin
                  o_sigma <= SIGMA_NEG;
               end
            end
            SIGMA_NEG: begin
               if (surf < band_lo) begin
                  o_sigma <= SIGMA_POS;
               end
            end
            default: begin
               o_sigma <= SIGMA_ZERO;   // unused code 2'b10
            end
         endcase
      end
   end

   // inside the band sigma holds, the band width sets the
   // oscillation amplitude of the tank

endmodule

`default_nettype wire

// ==== bridge_startup_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_startup_sequencer #(
   parameter int BOOT_CYCLES      = hybrid_tank_pkg::BOOT_CYCLES,
   parameter int PRECHARGE_CYCLES = hybrid_tank_pkg::PRECHARGE_CYCLES
) (
   input  logic                               ADA_DCO,
   input  logic                               i_reset,
   input  logic                               i_enable,
   input  hybrid_tank_pkg::sigma_t            i_sigma,   // from the law
   output logic [hybrid_tank_pkg::GATE_W-1:0] o_gate,
   output hybrid_tank_pkg::bridge_phase_t     o_phase,
   output hybrid_tank_pkg::sigma_t            o_sigma    // effective sigma
);

   import hybrid_tank_pkg::*;

   localparam int CNT_MAX = (BOOT_CYCLES > PRECHARGE_CYCLES) ? BOOT_CYCLES : PRECHARGE_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   bridge_phase_t     phase_d;
   logic [CNT_W-1:0]  cnt_q;     // cycles spent in the current phase
   logic [CNT_W-1:0]  cnt_d;
   sigma_t            sigma_d;
   logic [GATE_W-1:0] pat_d;
   logic [GATE_W-1:0] gate_d;
   logic              shoot_through;

   function automatic logic [GATE_W-1:0] sigma_to_gate(input sigma_t s);
      case (s)
         SIGMA_POS: sigma_to_gate = GATE_POS;
         SIGMA_NEG: sigma_to_gate = GATE_NEG;
         default:   sigma_to_gate = GATE_LOW;   // zero means low side on
      endcase
   endfunction

   // ==========================================================================
   // start-up fsm, enable low always drops back to idle
   // ==========================================================================
   always_comb begin
      phase_d = o_phase;
      cnt_d   = cnt_q + 1'b1;
      if (!i_enable) begin
         phase_d = PHASE_IDLE;
         cnt_d   = '0;
      end else begin
         case (o_phase)
            PHASE_IDLE: begin
               phase_d = PHASE_BOOT;
               cnt_d   = '0;
            end
            PHASE_BOOT: begin
               if (cnt_q == CNT_W'(BOOT_CYCLES - 1)) begin
                  phase_d = PHASE_PRECHARGE;
                  cnt_d   = '0;
               end
            end
            PHASE_PRECHARGE: begin
               if (cnt_q == CNT_W'(PRECHARGE_CYCLES - 1)) begin
                  phase_d = PHASE_RUN;
                  cnt_d   = '0;
               end
            end
            default: cnt_d = '0;   // run, counter parked
         endcase
      end
   end

   // gate pattern and effective sigma for the next phase
   always_comb begin
      case (phase_d)
         PHASE_BOOT: begin
            sigma_d = SIGMA_ZERO;
            pat_d   = GATE_LOW;   // q3 q4 charge the bootstrap caps
         end
         PHASE_PRECHARGE: begin
            sigma_d = SIGMA_POS;
            pat_d   = GATE_POS;
         end
         PHASE_RUN: begin
            sigma_d = i_sigma;
            pat_d   = sigma_to_gate(i_sigma);
         end
         default: begin
            sigma_d = SIGMA_ZERO;
            pat_d   = GATE_OFF;
         end
      endcase
   end

   // both switches of one leg never on together
   assign shoot_through = (pat_d[0] & pat_d[2]) | (pat_d[1] & pat_d[3]);
   assign gate_d        = shoot_through ? GATE_OFF : pat_d;

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_phase <= PHASE_IDLE;
         cnt_q   <= '0;
         o_gate  <= GATE_OFF;
         o_sigma <= SIGMA_ZERO;
      end else begin
         o_phase <= phase_d;
         cnt_q   <= cnt_d;
         o_gate  <= gate_d;
         o_sigma <= sigma_d;
      end
   end

endmodule

`default_nettype wire

// ==== dead_time_insert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dead_time_insert #(
   parameter int N_GATE      = hybrid_tank_pkg::GATE_W,
   parameter int DEAD_CYCLES = hybrid_tank_pkg::DEAD_CYCLES
) (
   input  logic              ADA_DCO,
   input  logic              i_reset,
   input  logic [N_GATE-1:0] i_gate,   // requested gates
   output logic [N_GATE-1:0] o_gate    // gates to the drivers
);

   // counter must hold DEAD_CYCLES itself
   localparam int CNT_W = (DEAD_CYCLES > 0) ? $clog2(DEAD_CYCLES + 1) : 1;

   logic [CNT_W-1:0] cnt_q [N_GATE];   // one per gate

   // ==========================================================================
   // turn-on delayed, turn-off immediate
   // ==========================================================================
   // a gate only rises once its request has been stable for the dead time.
   // the leg partner drops its request before this one is raised, so the
   // partner is already off for at least DEAD_CYCLES when this gate comes on

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         for (int g = 0; g < N_GATE; g++) begin
            cnt_q[g] <= '0;
         end
         o_gate <= '0;
      end else begin
         for (int g = 0; g < N_GATE; g++) begin
            if (!i_gate[g]) begin
               cnt_q[g]  <= '0;      // restart dead time
               o_gate[g] <= 1'b0;    // off at once
            end else if (cnt_q[g] == CNT_W'(DEAD_CYCLES)) begin
               o_gate[g] <= 1'b1;    // dead time elapsed
            end else begin
               cnt_q[g]  <= cnt_q[g] + 1'b1;
            end
         end
      end
   end

   // a glitching request restarts the count, so short pulses
   // never reach the bridge

endmodule

`default_nettype wire

// ==== hybrid_tank_control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hybrid_tank_control_top #(
   parameter int SAMPLE_W         = hybrid_tank_pkg::SAMPLE_W,
   parameter int GAIN_W           = hybrid_tank_pkg::GAIN_W,
   parameter int MU_VC            = hybrid_tank_pkg::MU_VC,
   parameter int MU_IC            = hybrid_tank_pkg::MU_IC,
   parameter int BOOT_CYCLES      = hybrid_tank_pkg::BOOT_CYCLES,
   parameter int PRECHARGE_CYCLES = hybrid_tank_pkg::PRECHARGE_CYCLES,
   parameter int N_GATE           = hybrid_tank_pkg::GATE_W,
   parameter int DEAD_CYCLES      = hybrid_tank_pkg::DEAD_CYCLES
) (
   input  logic                                 ADA_DCO,       // tank adc data clock
   input  logic                                 i_reset,
   input  logic signed [SAMPLE_W-1:0]           i_vc_raw,
   input  logic signed [SAMPLE_W-1:0]           i_ic_raw,
   input  logic                                 i_vc_or,
   input  logic                                 i_ic_or,
   input  hybrid_tank_pkg::ctrl_mode_t          i_mode,
   input  logic signed [GAIN_W-1:0]             i_slope,
   input  logic [hybrid_tank_pkg::THRESH_W-1:0] i_threshold,
   input  logic                                 i_enable,      // converter on
   output logic [N_GATE-1:0]                    o_gate,        // q1..q4
   output hybrid_tank_pkg::sigma_t              o_sigma,
   output hybrid_tank_pkg::bridge_phase_t       o_phase,
   output logic [SAMPLE_W-1:0]                  o_dac_vc,      // monitor dac
   output logic                                 o_adc_or
);

   import hybrid_tank_pkg::*;

   // ==========================================================================
   // stage links
   // ==========================================================================
   logic signed [SAMPLE_W-1:0] cap_vc;
   logic signed [SAMPLE_W-1:0] cap_ic;
   sigma_t                     law_sigma;   // raw law output
   logic [N_GATE-1:0]          seq_gate;    // gates before dead time

   adc_sample_capture #(.SAMPLE_W(SAMPLE_W)) adc_sample_capture_inst (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_vc_raw (i_vc_raw),
      .i_ic_raw (i_ic_raw),
      .i_vc_or  (i_vc_or),
      .i_ic_or  (i_ic_or),
      .o_vc     (cap_vc),
      .o_ic     (cap_ic),
      .o_dac_vc (o_dac_vc),
      .o_adc_or (o_adc_or)
   );

   // two cycle law, products then hysteresis
   switching_surface_law #(
      .SAMPLE_W (SAMPLE_W),
      .GAIN_W   (GAIN_W),
      .MU_VC    (MU_VC),
      .MU_IC    (MU_IC)
   ) switching_surface_law_inst (
      .ADA_DCO     (ADA_DCO),
      .i_reset     (i_reset),
      .i_vc        (cap_vc),
      .i_ic        (cap_ic),
      .i_mode      (i_mode),
      .i_slope     (i_slope),
      .i_threshold (i_threshold),
      .o_sigma     (law_sigma)
   );

   bridge_startup_sequencer #(
      .BOOT_CYCLES      (BOOT_CYCLES),
      .PRECHARGE_CYCLES (PRECHARGE_CYCLES)
   ) bridge_startup_sequencer_inst (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_enable (i_enable),
      .i_sigma  (law_sigma),
      .o_gate   (seq_gate),
      .o_phase  (o_phase),
      .o_sigma  (o_sigma)   // effective sigma after start-up gating
   );

   dead_time_insert #(
      .N_GATE      (N_GATE),
      .DEAD_CYCLES (DEAD_CYCLES)
   ) dead_time_insert_inst (
      .ADA_DCO (ADA_DCO),
      .i_reset (i_reset),
      .i_gate  (seq_gate),
      .o_gate  (o_gate)
   );

endmodule

`default_nettype wire

// ==== tb_hybrid_tank_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hybrid_tank_control;

   import hybrid_tank_pkg::*;

   localparam int PERIOD    = 20;
   localparam int BOOT      = BOOT_CYCLES;
   localparam int PRE       = PRECHARGE_CYCLES;
   localparam int DEAD      = DEAD_CYCLES;
   localparam int PAIR_HOLD = DEAD + 6;         // sigma latency plus turn-on delay
   localparam int RUN_WAIT  = BOOT + PRE + 8;
   // reset, capture, two start-ups, 22 held pairs and the off hold, theta sweep
   localparam int TEST_CYCLES = 16 + 30 + 2 * (RUN_WAIT + DEAD + 4) + 23 * PAIR_HOLD + 40;

   logic                       ADA_DCO;
   logic                       i_reset;
   logic signed [SAMPLE_W-1:0] i_vc_raw;
   logic signed [SAMPLE_W-1:0] i_ic_raw;
   logic                       i_vc_or;
   logic                       i_ic_or;
   ctrl_mode_t                 i_mode;
   logic signed [GAIN_W-1:0]   i_slope;
   logic [THRESH_W-1:0]        i_threshold;
   logic                       i_enable;
   logic [3:0]                 o_gate;
   sigma_t                     o_sigma;
   bridge_phase_t              o_phase;
   logic [SAMPLE_W-1:0]        o_dac_vc;
   logic                       o_adc_or;

   int          err_sigma, err_phase, err_gate, err_dac, err_flag, err_misc;
   logic [31:0] rng = 32'd45;
   sigma_t      exp_sig;                        // model copy of o_sigma
   logic [3:0]  prev_gate = '0;
   int          off_cnt [4];                    // cycles each gate has been off
   int          rise_cnt;

   hybrid_tank_control_top hybrid_tank_control_top_inst (
      .ADA_DCO     (ADA_DCO),
      .i_reset     (i_reset),
      .i_vc_raw    (i_vc_raw),
      .i_ic_raw    (i_ic_raw),
      .i_vc_or     (i_vc_or),
      .i_ic_or     (i_ic_or),
      .i_mode      (i_mode),
      .i_slope     (i_slope),
      .i_threshold (i_threshold),
      .i_enable    (i_enable),
      .o_gate      (o_gate),
      .o_sigma     (o_sigma),
      .o_phase     (o_phase),
      .o_dac_vc    (o_dac_vc),
      .o_adc_or    (o_adc_or)
   );

   always #(PERIOD / 2) ADA_DCO = ~ADA_DCO;

   // ==========================================================================
   // reference model
   // ==========================================================================
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int next_sample();
      rng = xorshift32(rng);
      return int'($signed(rng[13:0]));   // full 14 bit signed range
   endfunction

   // sensor polarity flip wraps at 14 bits
   function automatic longint negate_sample(input int raw);
      logic signed [13:0] w;
      w = 14'(-raw);
      return longint'(w);
   endfunction

   function automatic logic [13:0] expected_dac(input int raw);
      int v;
      v = 8191 - raw;
      return 14'(v);                     // mod 2^14
   endfunction

   function automatic longint surface_value(input int vc_raw, input int ic_raw,
                                            input ctrl_mode_t mode, input int slope);
      longint s;
      s = longint'(MU_VC) * 16 * negate_sample(vc_raw);
      if (mode != MODE_THETA) begin
         s = s + longint'(MU_IC) * slope * negate_sample(ic_raw);
      end
      return s;
   endfunction

   // off and hold park the surface hysteresis at zero
   function automatic sigma_t next_sigma(input sigma_t prev, input longint s,
                                         input longint thr, input ctrl_mode_t mode);
      if (mode == MODE_OFF || mode == MODE_HOLD) return SIGMA_ZERO;
      if (prev == SIGMA_ZERO) return SIGMA_POS;
      if (prev == SIGMA_POS && s > thr) return SIGMA_NEG;
      if (prev == SIGMA_NEG && s < -thr) return SIGMA_POS;
      return prev;
   endfunction

   function automatic logic [3:0] gate_pattern(input sigma_t s);
      case (s)
         SIGMA_POS: return 4'b1001;      // q1 q4
         SIGMA_NEG: return 4'b0110;      // q2 q3
         default:   return 4'b1100;      // q3 q4 low side
      endcase
   endfunction

   // ==========================================================================
   // compare tasks
   // ==========================================================================
   task automatic check_sigma(input sigma_t exp, input sigma_t act);
      if (exp !== act) begin
         $display("FAILED t=%0t o_sigma expected=%b actual=%b", $time, exp, act);
         err_sigma++;
      end
   endtask

   task automatic check_phase(input bridge_phase_t exp, input bridge_phase_t act);
      if (exp !== act) begin
         $display("FAILED t=%0t o_phase expected=%0d actual=%0d", $time, exp, act);
         err_phase++;
      end
   endtask

   task automatic check_gate(input logic [3:0] exp, input logic [3:0] act);
      if (exp !== act) begin
         $display("FAILED t=%0t o_gate expected=%b actual=%b", $time, exp, act);
         err_gate++;
      end
   endtask

   task automatic check_dac(input logic [13:0] exp, input logic [13:0] act);
      if (exp !== act) begin
         $display("FAILED t=%0t o_dac_vc expected=%h actual=%h", $time, exp, act);
         err_dac++;
      end
   endtask

   task automatic check_flag(input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAILED t=%0t o_adc_or expected=%b actual=%b", $time, exp, act);
         err_flag++;
      end
   endtask

   // legs q1/q3 and q2/q4 watched on every cycle
   always @(negedge ADA_DCO) begin
      int g;
      for (g = 0; g < 4; g++) begin
         if (o_gate[g] === 1'b1 && prev_gate[g] === 1'b0) begin
            rise_cnt++;
            if (off_cnt[g ^ 2] < DEAD) begin
               $display("%0t: gate %0d rose %0d cycles after its leg partner fell",
                        $time, g, off_cnt[g ^ 2]);
               err_misc++;
            end
         end
      end
      if ((o_gate[0] && o_gate[2]) || (o_gate[1] && o_gate[3])) begin
         $display("%0t: shoot-through, both switches of one leg on, o_gate=%b", $time, o_gate);
         err_misc++;
      end
      for (g = 0; g < 4; g++) begin
         off_cnt[g] = (o_gate[g] !== 1'b0) ? 0 : ((off_cnt[g] < 1000) ? off_cnt[g] + 1 : 1000);
      end
      prev_gate = o_gate;
   end

   // ==========================================================================
   // tests
   // ==========================================================================
   // sigma moves exactly 4 falling edges after a held sample pair
   task automatic apply_pair(input int vc_raw, input int ic_raw);
      sigma_t prev;
      prev    = exp_sig;
      exp_sig = next_sigma(prev, surface_value(vc_raw, ic_raw, i_mode, i_slope),
                           longint'(i_threshold), i_mode);
      i_vc_raw = 14'(vc_raw);
      i_ic_raw = 14'(ic_raw);
      repeat (3) @(negedge ADA_DCO);
      check_sigma(prev, o_sigma);
      @(negedge ADA_DCO);
      check_sigma(exp_sig, o_sigma);
      repeat (PAIR_HOLD - 4) @(negedge ADA_DCO);
      check_gate(gate_pattern(exp_sig), o_gate);   // settled after dead time
   endtask

   task automatic wait_run;
      int n;
      n = 0;
      while (o_phase !== PHASE_RUN && n < RUN_WAIT) begin
         @(negedge ADA_DCO);
         n++;
      end
      if (o_phase !== PHASE_RUN) begin
         $display("%0t: bridge did not reach the run phase within %0d cycles", $time, RUN_WAIT);
         err_misc++;
      end
      repeat (DEAD + 2) @(negedge ADA_DCO);
   endtask

   task automatic capture_and_monitor;
      int k;
      int raw;
      check_flag(1'b0, o_adc_or);
      for (k = 0; k < 20; k++) begin
         raw = (k == 0) ? -8192 : next_sample();   // full scale wraps to itself
         i_vc_raw = 14'(raw);
         @(negedge ADA_DCO);
         check_dac(expected_dac(raw), o_dac_vc);
      end
      i_ic_or = 1'b1;
      @(negedge ADA_DCO);
      i_ic_or = 1'b0;
      check_flag(1'b1, o_adc_or);
      repeat (4) @(negedge ADA_DCO);
      check_flag(1'b1, o_adc_or);   // sticky
      i_vc_raw = '0;
   endtask

   task automatic startup_sequence;
      int k;
      i_mode   = MODE_PHI;         // zero samples let the law settle at pos
      i_enable = 1'b1;
      for (k = 0; k <= BOOT + PRE; k++) begin
         @(negedge ADA_DCO);
         if (k < BOOT) check_phase(PHASE_BOOT, o_phase);
         else if (k < BOOT + PRE) check_phase(PHASE_PRECHARGE, o_phase);
         else check_phase(PHASE_RUN, o_phase);
         if (k == BOOT - 1) check_gate(4'b1100, o_gate);
         if (k == BOOT + PRE - 1) check_gate(4'b1001, o_gate);
      end
      exp_sig = SIGMA_POS;
      check_sigma(exp_sig, o_sigma);
      i_enable = 1'b0;
      repeat (2) @(negedge ADA_DCO);
      check_gate(4'b0000, o_gate);
      check_phase(PHASE_IDLE, o_phase);
      i_enable = 1'b1;
      wait_run();
      check_sigma(exp_sig, o_sigma);
   endtask

   task automatic phi_hysteresis;
      int k;
      apply_pair(-100, 0);          // above the band
      apply_pair(0, 0);             // inside the band so sigma holds
      apply_pair(100, 0);           // below the band
      for (k = 0; k < 8; k++) begin
         apply_pair(next_sample(), next_sample());
      end
      apply_pair(0, 0);
   endtask

   task automatic dead_time_toggle;
      int k;
      int rises;
      rises = rise_cnt;
      for (k = 0; k < 6; k++) begin
         apply_pair((k % 2 == 0) ? -150 : 150, 0);
      end
      if (rise_cnt - rises < 6) begin
         $display("%0t: too few gate turn-ons while sigma toggled", $time);
         err_misc++;
      end
   endtask

   task automatic theta_ignores_ic;
      int k;
      apply_pair(0, 0);
      i_mode = MODE_THETA;
      apply_pair(50, 0);            // vc inside the band
      for (k = 0; k < 20; k++) begin
         i_ic_raw = 14'(next_sample());
         @(negedge ADA_DCO);
         check_sigma(exp_sig, o_sigma);
      end
      apply_pair(-150, next_sample());
      apply_pair(150, next_sample());
   endtask

   task automatic off_mode;
      i_mode  = MODE_OFF;
      exp_sig = SIGMA_ZERO;
      repeat (PAIR_HOLD) @(negedge ADA_DCO);
      check_sigma(exp_sig, o_sigma);
      check_gate(4'b1100, o_gate);
      check_phase(PHASE_RUN, o_phase);
   endtask

   // ==========================================================================
   // main sequence and watchdog
   // ==========================================================================
   initial begin
      ADA_DCO     = 1'b0;
      i_reset     = 1'b1;
      i_vc_raw    = '0;
      i_ic_raw    = '0;
      i_vc_or     = 1'b0;
      i_ic_or     = 1'b0;
      i_mode      = MODE_OFF;       // law parked until start-up
      i_slope     = 8'sd16;
      i_threshold = 24'd100000;
      i_enable    = 1'b0;
      repeat (16) @(negedge ADA_DCO);
      i_reset = 1'b0;
      capture_and_monitor();
      startup_sequence();
      phi_hysteresis();
      dead_time_toggle();
      theta_ignores_ic();
      off_mode();
      $display("errors: sigma=%0d phase=%0d gate=%0d dac=%0d flag=%0d other=%0d",
               err_sigma, err_phase, err_gate, err_dac, err_flag, err_misc);
      if (err_sigma + err_phase + err_gate + err_dac + err_flag + err_misc == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      #(2 * TEST_CYCLES * PERIOD);
      $display("%0t: simulation timed out before the tests completed", $time);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hybrid_tank_control_top.f ====
hybrid_tank_pkg.sv
adc_sample_capture.sv
switching_surface_law.sv
bridge_startup_sequencer.sv
dead_time_insert.sv
hybrid_tank_control_top.sv
tb_hybrid_tank_control.sv

// ==== Bender.yml ====
package:
  name: hybrid_tank_control

sources:
  # package first, then the pipeline stages and the top level
  - hybrid_tank_pkg.sv
  - adc_sample_capture.sv
  - switching_surface_law.sv
  - bridge_startup_sequencer.sv
  - dead_time_insert.sv
  - hybrid_tank_control_top.sv
  - target: test
    files:
      - tb_hybrid_tank_control.sv
